// File: include/vec_cfg.svh
// Vector coprocessor configuration of lane geometry, element width and register map
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Lane geometry
// Element k of a vector lives in lane k mod 4, slot k div 4
`define VEC_NR_LANES       4
`define VEC_ELEMS_PER_LANE 4
`define VEC_NR_VREGS       8

// Datapath and bus widths
`define VEC_ELEM_WIDTH     32
`define VEC_WB_ADR_WIDTH   4

// Wishbone word addresses
`define VEC_ADR_INSN       4'd0
`define VEC_ADR_SCALAR     4'd1
`define VEC_ADR_RESULT     4'd2
`define VEC_ADR_STATUS     4'd3

`endif

// File: hdl/vec_pkg.sv
// Vector coprocessor types shared by the dispatcher, the sequencer and the lanes
`include "vec_cfg.svh"

package vec_pkg;

  typedef logic [`VEC_ELEM_WIDTH-1:0]               elem_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0]         vreg_t;
  typedef logic [$clog2(`VEC_ELEMS_PER_LANE)-1:0]   slot_t;
  typedef logic [$clog2(`VEC_NR_LANES)-1:0]         lane_idx_t;

  typedef enum logic [3:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VAND    = 4'd2,
    VOR     = 4'd3,
    VXOR    = 4'd4,
    VADDX   = 4'd5,  // vs2 + scalar
    VBCAST  = 4'd6,
    VINS    = 4'd7,
    VEXT    = 4'd8,
    VREDSUM = 4'd9
  } vec_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'd0,
    SEQ_RUN     = 2'd1,
    SEQ_COMBINE = 2'd2
  } seq_state_e;

  // Instruction word as written to INSN with the MSB first
  typedef struct packed {
    logic [11:0] rsvd_hi;
    logic [3:0]  elem_idx;
    logic        rsvd_15;
    vreg_t       vs2;
    logic        rsvd_11;
    vreg_t       vs1;
    logic        rsvd_7;
    vreg_t       vd;
    vec_op_e     op;
  } vec_insn_t;

  typedef struct packed {
    vec_insn_t insn;
    elem_t     scalar;
  } vec_req_t;

  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
    slot_t   slot;
  } lane_req_t;

  // Value is the extracted element or the partial sum
  typedef struct packed {
    logic  done;
    elem_t value;
  } lane_resp_t;

endpackage

// File: hdl/vec_dispatcher.sv
// Wishbone classic slave front end that decodes the register map and issues instructions
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`VEC_WB_ADR_WIDTH-1:0] wb_adr_i,
  input  logic [`VEC_ELEM_WIDTH-1:0]   wb_dat_i,
  output logic [`VEC_ELEM_WIDTH-1:0]   wb_dat_o,
  output logic                         wb_ack_o,
  // Sequencer request channel
  output vec_req_t                     req_o,
  output logic                         req_valid_o,
  input  logic                         req_ready_i,
  // Sequencer status
  input  logic                         busy_i,
  input  logic [`VEC_ELEM_WIDTH-1:0]   result_i
);

  logic     ack_q;
  logic     req_valid_q;
  elem_t    scalar_q;
  vec_req_t req_q;
  elem_t    dat_q;
  elem_t    rd_data;
  logic     acc_start;
  logic     insn_wr;
  logic     scalar_wr;

  // New access seen, not yet answered and no instruction pending
  assign acc_start = wb_cyc_i && wb_stb_i && !ack_q && !req_valid_q;
  assign insn_wr   = wb_we_i && (wb_adr_i == `VEC_ADR_INSN);
  assign scalar_wr = wb_we_i && (wb_adr_i == `VEC_ADR_SCALAR);

  ////////////////////////////////////////////////////////////
  // Register map read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      `VEC_ADR_SCALAR: rd_data = scalar_q;
      `VEC_ADR_RESULT: rd_data = result_i;
      `VEC_ADR_STATUS: rd_data = {{(`VEC_ELEM_WIDTH-1){1'b0}}, busy_i};
      default:         rd_data = '0;  // INSN and unmapped read as zero
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q       <= 1'b0;
      req_valid_q <= 1'b0;
      scalar_q    <= '0;
    end else begin
      ack_q <= 1'b0;
      if (req_valid_q) begin
        // Bus cycle stays open until the sequencer takes the instruction
        if (req_ready_i) begin
          req_valid_q <= 1'b0;
          ack_q       <= 1'b1;
        end
      end else if (acc_start) begin
        if (insn_wr) begin
          req_valid_q <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
        if (scalar_wr) begin
          scalar_q <= wb_dat_i;
        end
      end
    end
  end

  // Request payload and read data
  always_ff @(posedge clk_i) begin
    if (acc_start) begin
      dat_q <= rd_data;
      if (insn_wr) begin
        req_q.insn   <= vec_insn_t'(wb_dat_i);
        req_q.scalar <= scalar_q;
      end
    end
  end

  assign wb_ack_o    = ack_q;
  assign wb_dat_o    = dat_q;
  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

endmodule

// File: hdl/vec_sequencer.sv
// Single-instruction sequencer that broadcasts to the lanes and forms the scalar result
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Dispatcher side
  input  vec_req_t                       req_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output logic                           busy_o,
  output logic [`VEC_ELEM_WIDTH-1:0]     result_o,
  // Lane side
  output lane_req_t                      lane_req_o,
  output logic                           lane_start_o,
  output logic [`VEC_NR_LANES-1:0]       lane_sel_o,
  input  lane_resp_t [`VEC_NR_LANES-1:0] lane_resp_i
);

  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);
  localparam int unsigned SLOT_W = $clog2(`VEC_ELEMS_PER_LANE);

  seq_state_e                 state_q;
  vec_op_e                    op_q;
  logic [`VEC_NR_LANES-1:0]   sel_q;
  elem_t                      result_q;
  logic                       accept;
  lane_idx_t                  req_lane;
  logic [`VEC_NR_LANES-1:0]   sel_dec;
  logic [`VEC_NR_LANES-1:0]   done_vec;
  logic                       all_done;
  elem_t                      ext_val;
  elem_t                      red_sum;

  assign req_ready_o = (state_q == SEQ_IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign busy_o      = (state_q != SEQ_IDLE);

  ////////////////////////////////////////////////////////////
  // Element index decode and broadcast
  ////////////////////////////////////////////////////////////

  // Low index bits pick the lane, high bits the slot
  assign req_lane = req_i.insn.elem_idx[LANE_W-1:0];

  always_comb begin
    sel_dec = '1;
    if (req_i.insn.op == VINS || req_i.insn.op == VEXT) begin
      sel_dec           = '0;
      sel_dec[req_lane] = 1'b1;
    end
  end

  // Lanes capture the request in the accept cycle
  assign lane_start_o      = accept;
  assign lane_sel_o        = sel_dec;
  assign lane_req_o.op     = req_i.insn.op;
  assign lane_req_o.vd     = req_i.insn.vd;
  assign lane_req_o.vs1    = req_i.insn.vs1;
  assign lane_req_o.vs2    = req_i.insn.vs2;
  assign lane_req_o.scalar = req_i.scalar;
  assign lane_req_o.slot   = req_i.insn.elem_idx[LANE_W +: SLOT_W];

  ////////////////////////////////////////////////////////////
  // Lane completion and result forming
  ////////////////////////////////////////////////////////////

  always_comb begin
    ext_val = '0;
    red_sum = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      done_vec[i] = lane_resp_i[i].done;
      if (sel_q[i]) begin
        ext_val = ext_val | lane_resp_i[i].value;
      end
      red_sum = red_sum + lane_resp_i[i].value;
    end
  end

  // Unselected lanes count as finished
  assign all_done = &(done_vec | ~sel_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= SEQ_IDLE;
      result_q <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (accept) begin
            state_q <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          if (all_done) begin
            if (op_q == VREDSUM) begin
              state_q <= SEQ_COMBINE;
            end else begin
              state_q <= SEQ_IDLE;
              if (op_q == VEXT) begin
                result_q <= ext_val;
              end
            end
          end
        end
        SEQ_COMBINE: begin
          // Partial sums are settled one cycle after done
          result_q <= red_sum;
          state_q  <= SEQ_IDLE;
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= req_i.insn.op;
      sel_q <= sel_dec;
    end
  end

  assign result_o = result_q;

endmodule

// File: hdl/vec_lane.sv
// Vector lane with its register file slice, slot counter, ALU and reduction accumulator
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_lane import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  lane_req_t  lane_req_i,
  input  logic       lane_start_i,
  input  logic       lane_sel_i,
  output lane_resp_t lane_resp_o
);

  localparam int unsigned RF_DEPTH  = `VEC_NR_VREGS * `VEC_ELEMS_PER_LANE;
  localparam slot_t       SLOT_LAST = slot_t'(`VEC_ELEMS_PER_LANE - 1);

  // Register slice, indexed by {vreg, slot}
  elem_t     rf_q [RF_DEPTH];

  lane_req_t req_q;
  logic      active_q;
  slot_t     cnt_q;
  elem_t     value_q;
  logic      start;
  logic      single;
  logic      last;
  slot_t     slot;
  elem_t     op_a;
  elem_t     op_b;
  elem_t     alu_res;
  logic      wr_en;

  assign start  = lane_start_i && lane_sel_i;
  assign single = (req_q.op == VINS) || (req_q.op == VEXT);
  assign last   = single || (cnt_q == SLOT_LAST);
  assign slot   = single ? req_q.slot : cnt_q;

  assign op_a = rf_q[{req_q.vs1, slot}];
  assign op_b = rf_q[{req_q.vs2, slot}];

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_q.op)
      VADD:    alu_res = op_b + op_a;
      VSUB:    alu_res = op_b - op_a;  // vs2 - vs1
      VAND:    alu_res = op_b & op_a;
      VOR:     alu_res = op_b | op_a;
      VXOR:    alu_res = op_b ^ op_a;
      VADDX:   alu_res = op_b + req_q.scalar;
      VBCAST,
      VINS:    alu_res = req_q.scalar;
      default: alu_res = op_b;
    endcase
  end

  // Reduction and extract leave vd untouched
  assign wr_en = active_q && (req_q.op inside {VADD, VSUB, VAND, VOR, VXOR,
                                               VADDX, VBCAST, VINS});

  ////////////////////////////////////////////////////////////
  // Slot sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      if (last) begin
        active_q <= 1'b0;
      end
      cnt_q <= cnt_q + slot_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_q <= lane_req_i;
      // Extract is read here so the value is ready with done
      if (lane_req_i.op == VEXT) begin
        value_q <= rf_q[{lane_req_i.vs2, lane_req_i.slot}];
      end else begin
        value_q <= '0;
      end
    end else if (active_q && req_q.op == VREDSUM) begin
      value_q <= value_q + op_b;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      rf_q[{req_q.vd, slot}] <= alu_res;
    end
  end

  assign lane_resp_o.done  = active_q && last;
  assign lane_resp_o.value = value_q;

endmodule

// File: hdl/vec_top.sv
// Vector coprocessor top level joining the Wishbone front end, sequencer and lanes
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_top import vec_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`VEC_WB_ADR_WIDTH-1:0] wb_adr_i,
  input  logic [`VEC_ELEM_WIDTH-1:0]   wb_dat_i,
  output logic [`VEC_ELEM_WIDTH-1:0]   wb_dat_o,
  output logic                         wb_ack_o
);

  vec_req_t                       req;
  logic                           req_valid;
  logic                           req_ready;
  logic                           busy;
  elem_t                          result;
  lane_req_t                      lane_req;
  logic                           lane_start;
  logic [`VEC_NR_LANES-1:0]       lane_sel;
  lane_resp_t [`VEC_NR_LANES-1:0] lane_resp;

  vec_dispatcher u_dispatcher (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .req_o       (req),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .busy_i      (busy),
    .result_i    (result)
  );

  vec_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .busy_o       (busy),
    .result_o     (result),
    .lane_req_o   (lane_req),
    .lane_start_o (lane_start),
    .lane_sel_o   (lane_sel),
    .lane_resp_i  (lane_resp)
  );

  for (genvar i = 0; i < `VEC_NR_LANES; i++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .lane_req_i   (lane_req),
      .lane_start_i (lane_start),
      .lane_sel_i   (lane_sel[i]),
      .lane_resp_o  (lane_resp[i])
    );
  end

endmodule

// File: bench/vec_properties.sv
// Wishbone and sequencer handshake assertions bound to the vector coprocessor top level
`timescale 1ns/1ps

module vec_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic busy_i,
  input logic lane_start_i
);

  int unsigned prop_errors = 0;

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
      prop_errors++;
      $error("Wishbone ack without an active cycle and strobe");
    end

  // One ack per access
  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      prop_errors++;
      $error("Wishbone ack held for two cycles");
    end

  start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_start_i |-> !busy_i)
    else begin
      prop_errors++;
      $error("Lane start issued while the sequencer is busy");
    end

endmodule

bind vec_top vec_properties u_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .wb_cyc_i     (wb_cyc_i),
  .wb_stb_i     (wb_stb_i),
  .wb_ack_i     (wb_ack_o),
  .busy_i       (busy),
  .lane_start_i (lane_start)
);

// File: bench/vec_tb.sv
// Testbench that checks the vector coprocessor against a register file model
`timescale 1ns/1ps
`include "vec_cfg.svh"

module vec_tb import vec_pkg::*; ();

  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 2000;
  localparam int          NUM_ELEMS       = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;
  localparam logic [31:0] LFSR_MASK       = 32'hD000_0001;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [31:0] wb_rdat;
  logic        wb_ack;

  logic [31:0] lfsr;
  logic [31:0] model [`VEC_NR_VREGS][NUM_ELEMS];
  int          checks;
  int          errors;
  int          mark_checks;
  int          mark_errors;

  vec_top uut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Budget of cycles per test
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * 10);
    $display("Watchdog expired at %0t ns before all tests finished", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? LFSR_MASK : 32'd0);
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic [2:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(3);
    return r[2:0];
  endfunction

  // Fields as given by the instruction word layout
  function automatic logic [31:0] make_insn(input logic [3:0] op, input logic [2:0] vd,
                                            input logic [2:0] vs1, input logic [2:0] vs2,
                                            input logic [3:0] idx);
    return {12'd0, idx, 1'b0, vs2, 1'b0, vs1, 1'b0, vd, op};
  endfunction

  function automatic logic [31:0] alu_ref(input vec_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      default: return a ^ b;
    endcase
  endfunction

  function automatic logic [31:0] model_sum(input logic [2:0] v);
    logic [31:0] s;
    s = '0;
    for (int k = 0; k < NUM_ELEMS; k++) begin
      s = s + model[v][k];
    end
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // Wishbone access tasks
  ////////////////////////////////////////////////////////////

  // Strobe held until ack is seen at a clock edge
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int waits);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdata;
    waits  = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_ack);
    rdata = wb_rdat;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    int          waits;
    bus_access(1'b1, adr, data, unused, waits);
  endtask

  task automatic bus_read(input logic [3:0] adr, output logic [31:0] data);
    int waits;
    bus_access(1'b0, adr, '0, data, waits);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    do begin
      bus_read(`VEC_ADR_STATUS, status);
    end while (status[0]);
  endtask

  task automatic run_insn(input logic [31:0] insn);
    bus_write(`VEC_ADR_INSN, insn);
    wait_idle();
  endtask

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Extract every element of one register and compare
  task automatic check_vreg(input logic [2:0] v);
    logic [31:0] res;
    for (int k = 0; k < NUM_ELEMS; k++) begin
      run_insn(make_insn(VEXT, 3'd0, 3'd0, v, k[3:0]));
      bus_read(`VEC_ADR_RESULT, res);
      check_value($sformatf("RESULT v%0d[%0d]", v, k), model[v][k], res);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %-13s %0d checks, %0d errors", name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_status();
    logic [31:0] val;
    logic [31:0] res;
    bus_read(`VEC_ADR_STATUS, res);
    check_value("STATUS", 32'd0, res);
    bus_read(`VEC_ADR_RESULT, res);
    check_value("RESULT", 32'd0, res);
    val = rand_bits(32);
    bus_write(`VEC_ADR_SCALAR, val);
    bus_read(`VEC_ADR_SCALAR, res);
    check_value("SCALAR", val, res);
    finish_test("reset_status");
  endtask

  task automatic test_insert_extract();
    logic [31:0] val;
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      for (int k = 0; k < NUM_ELEMS; k++) begin
        val         = rand_bits(32);
        model[v][k] = val;
        bus_write(`VEC_ADR_SCALAR, val);
        run_insn(make_insn(VINS, v[2:0], 3'd0, 3'd0, k[3:0]));
      end
    end
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      check_vreg(v[2:0]);
    end
    finish_test("insert_extract");
  endtask

  task automatic test_elementwise();
    vec_op_e    ops [5] = '{VADD, VSUB, VAND, VOR, VXOR};
    logic [2:0] vd;
    logic [2:0] vs1;
    logic [2:0] vs2;
    foreach (ops[i]) begin
      vd  = rand_reg();
      vs1 = rand_reg();
      vs2 = rand_reg();
      run_insn(make_insn(ops[i], vd, vs1, vs2, 4'd0));
      // Each element depends only on the same element of the sources
      for (int k = 0; k < NUM_ELEMS; k++) begin
        model[vd][k] = alu_ref(ops[i], model[vs2][k], model[vs1][k]);
      end
      check_vreg(vd);
    end
    finish_test("elementwise");
  endtask

  task automatic test_scalar_ops();
    logic [31:0] val;
    logic [2:0]  vd;
    logic [2:0]  vs2;
    val = rand_bits(32);
    vd  = rand_reg();
    bus_write(`VEC_ADR_SCALAR, val);
    run_insn(make_insn(VBCAST, vd, 3'd0, 3'd0, 4'd0));
    for (int k = 0; k < NUM_ELEMS; k++) begin
      model[vd][k] = val;
    end
    check_vreg(vd);
    val = rand_bits(32);
    vd  = rand_reg();
    vs2 = rand_reg();
    bus_write(`VEC_ADR_SCALAR, val);
    run_insn(make_insn(VADDX, vd, 3'd0, vs2, 4'd0));
    for (int k = 0; k < NUM_ELEMS; k++) begin
      model[vd][k] = model[vs2][k] + val;
    end
    check_vreg(vd);
    finish_test("scalar_ops");
  endtask

  task automatic test_reduction();
    logic [2:0]  vd;
    logic [2:0]  vs2;
    logic [31:0] res;
    vs2 = rand_reg();
    vd  = vs2 + 3'd1;
    run_insn(make_insn(VREDSUM, vd, 3'd0, vs2, 4'd0));
    bus_read(`VEC_ADR_RESULT, res);
    check_value("RESULT sum", model_sum(vs2), res);
    // Destination equal to source
    vs2 = rand_reg();
    run_insn(make_insn(VREDSUM, vs2, 3'd0, vs2, 4'd0));
    bus_read(`VEC_ADR_RESULT, res);
    check_value("RESULT sum", model_sum(vs2), res);
    check_vreg(vs2);
    finish_test("reduction");
  endtask

  task automatic test_backpressure();
    logic [2:0]  r;
    logic [2:0]  vd;
    logic [2:0]  vs1;
    logic [2:0]  vs2;
    logic [31:0] exp_sum;
    logic [31:0] unused;
    logic [31:0] res;
    int          waits;
    r       = rand_reg();
    vd      = rand_reg();
    vs1     = rand_reg();
    vs2     = rand_reg();
    exp_sum = model_sum(r);
    bus_write(`VEC_ADR_INSN, make_insn(VREDSUM, r, 3'd0, r, 4'd0));
    bus_access(1'b1, `VEC_ADR_INSN, make_insn(VADD, vd, vs1, vs2, 4'd0), unused, waits);
    // Second write starts the cycle after the first ack
    // The VREDSUM holds the sequencer for four lane cycles and one combine cycle
    // before the next accept, whose ack follows one cycle later
    checks++;
    assert (waits >= 6) else begin
      errors++;
      $display("Second INSN write was acked after %0d cycles, before the first finished",
               waits);
    end
    wait_idle();
    bus_read(`VEC_ADR_RESULT, res);
    check_value("RESULT sum", exp_sum, res);
    for (int k = 0; k < NUM_ELEMS; k++) begin
      model[vd][k] = model[vs2][k] + model[vs1][k];
    end
    check_vreg(vd);
    finish_test("backpressure");
  endtask

  initial begin
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat      = '0;
    lfsr        = 32'd8182;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_status();
    test_insert_extract();
    test_elementwise();
    test_scalar_ops();
    test_reduction();
    test_backpressure();
    $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             uut.u_properties.prop_errors);
    if (errors == 0 && uut.u_properties.prop_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
hdl/vec_pkg.sv
hdl/vec_dispatcher.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_top.sv
bench/vec_properties.sv
bench/vec_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= vec_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
